// File: sources.f
design/cart_pkg.sv
design/rom_port_if.sv
design/image_loader.sv
design/header_detect.sv
design/bank_mapper.sv
design/rom_store.sv
design/save_ram.sv
design/bus_read_path.sv
design/cart_top.sv
dv/cart_checker.sv
dv/cart_tb.sv

// File: Makefile
all: run

obj_dir/Vcart_tb: sources.f design/*.sv dv/*.sv
	verilator --binary --timing -Wno-fatal --top-module cart_tb -f sources.f -Mdir obj_dir

run: obj_dir/Vcart_tb
	./obj_dir/Vcart_tb | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module cart_tb -f sources.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: dv/cart_tb.sv
// Table-driven testbench for cart_top with a reference ROM, SRAM and mapper model.
// The large download runs past two million words, so the run is long.
`timescale 1ns/100ps
`default_nettype none

module cart_tb;
	import cart_pkg::*;

	typedef enum logic [2:0] {
		OP_LOAD, OP_QUIRK, OP_READ, OP_WRITE, OP_RAND, OP_SAVEW, OP_SAVER, OP_STALL
	} op_t;

	// Load arg: bit 0 gaps, bits 2:1 header code; read/write arg: bit 0 register space
	typedef struct packed {
		op_t         op;
		logic [22:0] addr;
		logic [31:0] data;
		logic [3:0]  arg;
	} row_t;

	localparam logic [63:0] SRAM_CODES [5] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 "
	};
	localparam logic [63:0] LOAD_CODES [3] = '{64'h0, "T-81406 ", "T-113016"};

	// Word index of the first product-code word
	localparam int ID_WORD = int'(HEADER_ID_ADDR >> 1);

	logic        clk = 1'b0;
	logic        reset;
	logic        dl_active;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic        dl_valid;
	logic        dl_ready;
	logic [22:0] bus_addr;
	logic [15:0] bus_wdata;
	logic        bus_lwr;
	logic        bus_uwr;
	logic        bus_time;
	logic        bus_valid;
	logic        bus_ready;
	logic [15:0] rd_data;
	logic        rd_valid;
	logic        rd_ready = 1'b1;
	logic [14:0] save_addr;
	logic [7:0]  save_wdata;
	logic        save_we;
	logic [7:0]  save_rdata;
	logic        save_change;

	// Reference model state
	logic [15:0] rom_m [ROM_WORDS];
	logic [7:0]  sram_m [32768];
	logic [5:0]  bank_m [8];
	logic        bank_use_m = 1'b0;
	logic        sram_bank_m = 1'b0;
	logic        sram_q_m = 1'b0;
	logic        noram_q_m = 1'b0;
	logic [24:0] size_m = '0;
	logic [23:0] mask_m = '0;
	logic [63:0] id_m = '0;
	logic [15:0] lfsr = 16'd14;
	logic [15:0] stall_lfsr = 16'd14;
	logic        stall_en;
	row_t        rows [$];
	int          wd_cycles = 0;

	cart_top uut (.*);

	cart_checker chk (.clk, .reset, .rd_data, .rd_valid, .rd_ready, .bus_ready,
		.save_rdata, .save_change, .sram_quirk(uut.sram_quirk),
		.noram_quirk(uut.noram_quirk), .rom_addr(uut.rom_addr));

	always #50 clk = ~clk;

	// Random response stalls
	always @(posedge clk) begin
		if (stall_en) begin
			stall_lfsr = lfsr_next(stall_lfsr);
			rd_ready <= stall_lfsr[0];
		end else
			rd_ready <= 1'b1;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic void add(input op_t op, input logic [22:0] a, input logic [31:0] d,
		input logic [3:0] arg);
		rows.push_back('{op, a, d, arg});
	endfunction

	function automatic logic sram_select(input logic [22:0] a, input logic t);
		logic win;
		win = (a[22:20] == 3'd1) && !noram_q_m &&
			(sram_bank_m || (({2'b00, a} >= size_m) && !(a[19] && a[18])));
		return !t && (win || (sram_q_m && a == 23'h100000));
	endfunction

	// Bank window from address bits 21:19 once any bank register was written
	function automatic logic [23:0] model_translate(input logic [22:0] a);
		if (bank_use_m)
			return {bank_m[a[20:18]], a[17:0]};
		return {1'b0, a};
	endfunction

	function automatic logic [15:0] model_read(input logic [22:0] a, input logic t);
		logic [23:0] tr;
		if (t)
			return 16'hFFFF;
		if (sram_select(a, 1'b0))
			return {sram_m[a[14:0]], sram_m[a[14:0]]};
		tr = model_translate(a) & mask_m;
		return rom_m[tr[13:0]];
	endfunction

	function automatic void reg_write(input logic [22:0] a, input logic [15:0] d);
		if (size_m > 25'h200000 && a[2:0] != 3'd0) begin
			bank_m[a[2:0]] = d[5:0];
			bank_use_m = 1'b1;
		end else
			sram_bank_m = d[0];
	endfunction

	// ====================
	// Stimulus tasks
	task automatic load_image(input int words, input logic gaps, input logic [63:0] code);
		int          i;
		int          k;
		logic [15:0] d;
		i = 0;
		@(posedge clk);
		dl_active <= 1'b1;
		while (i < words) begin
			if (gaps && rand_bits(2) == 0)
				dl_valid <= 1'b0;
			else begin
				k = i - ID_WORD;
				if (code != 0 && k >= 0 && k < 4)
					d = {code[55 - 16 * k -: 8], code[63 - 16 * k -: 8]};
				else
					d = 16'(rand_bits(16));
				dl_addr  <= 25'(2 * i);
				dl_data  <= d;
				dl_valid <= 1'b1;
			end
			@(posedge clk);
			if (dl_valid && dl_ready) begin
				k = i - ID_WORD;
				rom_m[i % ROM_WORDS] = {dl_data[7:0], dl_data[15:8]};
				mask_m = mask_m | 24'(i);
				if (k >= 0 && k < 4)
					id_m[63 - 16 * k -: 16] = {dl_data[7:0], dl_data[15:8]};
				i++;
			end
		end
		dl_valid  <= 1'b0;
		dl_active <= 1'b0;
		size_m    = 25'(words);
		sram_q_m  = 1'b0;
		for (k = 0; k < 5; k++)
			if (id_m == SRAM_CODES[k])
				sram_q_m = 1'b1;
		noram_q_m = (id_m == LOAD_CODES[2]);
		repeat (3) @(posedge clk);
	endtask

	task automatic load_reset_model();
		size_m = '0;
		mask_m = '0;
	endtask

	task automatic bus_op(input logic [22:0] a, input logic [15:0] d, input logic wr,
		input logic t);
		if (!wr)
			chk.push_read(model_read(a, t));
		else if (t)
			reg_write(a, d);
		else if (sram_select(a, 1'b0)) begin
			sram_m[a[14:0]] = d[7:0];
			chk.expect_change();
		end
		@(posedge clk);
		bus_addr  <= a;
		bus_wdata <= d;
		bus_lwr   <= wr;
		bus_uwr   <= 1'b0;
		bus_time  <= t;
		bus_valid <= 1'b1;
		do @(posedge clk); while (!(bus_valid && bus_ready));
		if (!wr && !t && !sram_select(a, 1'b0))
			chk.check_rom_addr(model_translate(a));
		bus_valid <= 1'b0;
	endtask

	task automatic save_write(input logic [14:0] a, input logic [7:0] d);
		@(posedge clk);
		save_addr  <= a;
		save_wdata <= d;
		save_we    <= 1'b1;
		@(posedge clk);
		save_we    <= 1'b0;
		sram_m[a] = d;
	endtask

	task automatic save_read(input logic [14:0] a);
		@(posedge clk);
		save_addr <= a;
		@(posedge clk);
		@(posedge clk);
		chk.check_save(sram_m[a]);
	endtask

	// ====================
	// Table and main loop
	initial begin
		int          est;
		int          k;
		row_t        r;
		logic [22:0] a;
		reset <= 1'b1;
		dl_active <= 1'b0;
		dl_addr <= '0;
		dl_data <= '0;
		dl_valid <= 1'b0;
		bus_addr <= '0;
		bus_wdata <= '0;
		bus_lwr <= 1'b0;
		bus_uwr <= 1'b0;
		bus_time <= 1'b0;
		bus_valid <= 1'b0;
		save_addr <= '0;
		save_wdata <= '0;
		save_we <= 1'b0;
		stall_en <= 1'b0;
		for (k = 0; k < 8; k++)
			bank_m[k] = 6'(k);

		add(OP_LOAD, 0, 4096, 4'b0001);
		add(OP_QUIRK, 0, 0, 0);
		add(OP_RAND, 0, 64, 0);
		add(OP_READ, 23'h003ABC, 0, 0);
		add(OP_READ, 23'h0000C1, 0, 0);
		add(OP_READ, 23'h000000, 0, 1);
		add(OP_LOAD, 0, 4096, 4'b0011);
		add(OP_QUIRK, 0, 0, 0);
		add(OP_WRITE, 23'h100000, 32'h5A, 0);
		add(OP_READ, 23'h100000, 0, 0);
		add(OP_LOAD, 0, 4096, 4'b0101);
		add(OP_QUIRK, 0, 0, 0);
		add(OP_READ, 23'h100000, 0, 0);
		add(OP_LOAD, 0, 4096, 4'b0001);
		add(OP_WRITE, 23'h100010, 32'hC3, 0);
		add(OP_SAVER, 23'h10, 0, 0);
		add(OP_SAVEW, 23'h20, 32'h9E, 0);
		add(OP_READ, 23'h100020, 0, 0);
		add(OP_WRITE, 23'h000002, 32'h4, 1);
		add(OP_READ, 23'h080123, 0, 0);
		add(OP_STALL, 0, 1, 0);
		add(OP_RAND, 0, 32, 0);
		add(OP_STALL, 0, 0, 0);
		add(OP_LOAD, 0, 32'(MAPPER_SIZE_WORDS) + 32'd1024, 4'b0010);
		add(OP_QUIRK, 0, 0, 0);
		// Inside the image, so only the quirk address selects the SRAM
		add(OP_WRITE, 23'h100000, 32'hA7, 0);
		add(OP_READ, 23'h100000, 0, 0);
		add(OP_WRITE, 23'h000002, 32'h5, 1);
		add(OP_WRITE, 23'h000000, 32'h1, 1);
		add(OP_READ, 23'h080123, 0, 0);
		add(OP_WRITE, 23'h100040, 32'h11, 0);
		add(OP_READ, 23'h100040, 0, 0);
		add(OP_STALL, 0, 1, 0);
		add(OP_RAND, 0, 48, 0);
		add(OP_STALL, 0, 0, 0);

		// Watchdog budget from row lengths
		est = 0;
		foreach (rows[n]) begin
			if (rows[n].op == OP_LOAD)
				est += int'(rows[n].data) * 2 + 40;
			else if (rows[n].op == OP_RAND)
				est += int'(rows[n].data) * 30;
			else
				est += 40;
		end
		wd_cycles = est * 2 + 200;

		repeat (16) @(posedge clk);
		reset <= 1'b0;

		foreach (rows[n]) begin
			r = rows[n];
			case (r.op)
				OP_LOAD: begin
					load_reset_model();
					load_image(int'(r.data), r.arg[0], LOAD_CODES[r.arg[2:1]]);
				end
				OP_QUIRK: chk.check_quirks(sram_q_m, noram_q_m);
				OP_READ:  bus_op(r.addr, 16'h0, 1'b0, r.arg[0]);
				OP_WRITE: bus_op(r.addr, r.data[15:0], 1'b1, r.arg[0]);
				OP_RAND: begin
					for (k = 0; k < int'(r.data); k++) begin
						a = (size_m > 25'd4096) ? 23'(rand_bits(20)) : 23'(rand_bits(12));
						bus_op(a, 16'h0, 1'b0, 1'b0);
					end
				end
				OP_SAVEW: save_write(r.addr[14:0], r.data[7:0]);
				OP_SAVER: save_read(r.addr[14:0]);
				default:  stall_en <= r.data[0];
			endcase
			while (chk.outstanding() != 0)
				@(posedge clk);
			chk.end_test(n, r.op.name());
		end

		repeat (4) @(posedge clk);
		chk.report();
		if (chk.errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		wait (wd_cycles != 0);
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/cart_checker.sv
// Compares bus responses, mapped ROM addresses, save reads and quirk flags with expected values.
// Expected read data must be pushed in issue order.
`timescale 1ns/100ps
`default_nettype none

module cart_checker (
	input logic        clk,
	input logic        reset,
	input logic [15:0] rd_data,
	input logic        rd_valid,
	input logic        rd_ready,
	input logic        bus_ready,
	input logic [7:0]  save_rdata,
	input logic        save_change,
	input logic        sram_quirk,
	input logic        noram_quirk,
	input logic [23:0] rom_addr
);
	logic [15:0] exp_q [$];
	logic        held;
	logic [15:0] held_data;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_base = 0;
	int          change_exp = 0;
	int          change_seen = 0;

	function automatic void push_read(input logic [15:0] d);
		exp_q.push_back(d);
	endfunction

	function automatic int outstanding();
		return exp_q.size();
	endfunction

	function automatic void expect_change();
		change_exp++;
	endfunction

	function automatic void compare(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endfunction

	function automatic void check_save(input logic [7:0] exp);
		compare("save_rdata", {24'h0, save_rdata}, {24'h0, exp});
	endfunction

	function automatic void check_quirks(input logic s, input logic n);
		compare("sram_quirk", {31'h0, sram_quirk}, {31'h0, s});
		compare("noram_quirk", {31'h0, noram_quirk}, {31'h0, n});
	endfunction

	// Translated word address of the read being accepted
	function automatic void check_rom_addr(input logic [23:0] exp);
		compare("rom_addr", {8'h00, rom_addr}, {8'h00, exp});
	endfunction

	function automatic void end_test(input int n, input string name);
		tests++;
		if (errors == test_base)
			$display("test %0d %s: ok", n, name);
		else
			$display("test %0d %s: %0d errors", n, name, errors - test_base);
		test_base = errors;
	endfunction

	function automatic void report();
		checks++;
		if (change_seen != change_exp) begin
			errors++;
			$display("save_change pulsed %0d times but %0d SRAM writes were made",
				change_seen, change_exp);
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
	endfunction

	// ====================
	// Response watch
	always @(posedge clk) begin
		if (reset) begin
			held <= 1'b0;
		end else begin
			if (save_change)
				change_seen++;
			if (rd_valid && bus_ready) begin
				errors++;
				$display("bus_ready was high at %0t while a response was pending", $time);
			end
			if (held && !rd_valid) begin
				errors++;
				$display("Response at %0t was dropped before rd_ready", $time);
			end else if (held) begin
				compare("rd_data held", {16'h0, rd_data}, {16'h0, held_data});
			end
			if (rd_valid && rd_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Unexpected response at %0t with data %h", $time, rd_data);
				end else begin
					compare("rd_data", {16'h0, rd_data}, {16'h0, exp_q.pop_front()});
				end
			end
			held      <= rd_valid && !rd_ready;
			held_data <= rd_data;
		end
	end

endmodule

`default_nettype wire

// File: design/cart_top.sv
// Mega Drive cartridge: image download, quirks, bank mapper, battery SRAM.
// Single clock; all handshakes are valid/ready.
`timescale 1ns/100ps
`default_nettype none

module cart_top (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                dl_active,
	input  logic [cart_pkg::DL_ADDR_BITS-1:0]   dl_addr,
	input  logic [cart_pkg::DATA_BITS-1:0]      dl_data,
	input  logic                                dl_valid,
	output logic                                dl_ready,
	input  logic [cart_pkg::BUS_ADDR_BITS-1:0]  bus_addr,
	input  logic [cart_pkg::DATA_BITS-1:0]      bus_wdata,
	input  logic                                bus_lwr,
	input  logic                                bus_uwr,
	input  logic                                bus_time,
	input  logic                                bus_valid,
	output logic                                bus_ready,
	output logic [cart_pkg::DATA_BITS-1:0]      rd_data,
	output logic                                rd_valid,
	input  logic                                rd_ready,
	input  logic [cart_pkg::SRAM_ADDR_BITS-1:0] save_addr,
	input  logic [cart_pkg::SRAM_DATA_BITS-1:0] save_wdata,
	input  logic                                save_we,
	output logic [cart_pkg::SRAM_DATA_BITS-1:0] save_rdata,
	output logic                                save_change
);
	import cart_pkg::*;

	logic [ROM_SIZE_BITS-1:0]  rom_size;
	logic [ROM_ADDR_BITS-1:0]  rom_mask;
	logic [ROM_ADDR_BITS-1:0]  rom_addr;
	logic                      sram_bank;
	logic                      sram_quirk;
	logic                      noram_quirk;
	logic [SRAM_ADDR_BITS-1:0] bus_sram_addr;
	logic [SRAM_DATA_BITS-1:0] bus_sram_wdata;
	logic                      bus_sram_we;
	logic [SRAM_DATA_BITS-1:0] bus_sram_q;

	rom_port_if rom ();

	image_loader u_loader (.clk, .reset, .dl_active, .dl_addr, .dl_data, .dl_valid,
		.dl_ready, .rom_size, .rom_mask, .rom(rom.load_client));

	header_detect u_header (.clk, .reset, .dl_active, .dl_addr, .dl_data, .dl_valid,
		.dl_ready, .sram_quirk, .noram_quirk);

	bank_mapper u_mapper (.clk, .reset, .bus_addr, .bus_wdata, .bus_lwr, .bus_time,
		.bus_valid, .bus_ready, .rom_size, .rom_addr, .sram_bank);

	rom_store u_rom (.clk, .reset, .rom(rom.store));

	save_ram u_sram (.clk, .bus_sram_addr, .bus_sram_wdata, .bus_sram_we, .bus_sram_q,
		.save_addr, .save_wdata, .save_we, .save_rdata);

	bus_read_path u_bus (.clk, .reset, .bus_addr, .bus_wdata, .bus_lwr, .bus_uwr,
		.bus_time, .bus_valid, .bus_ready, .rd_data, .rd_valid, .rd_ready, .rom_addr,
		.rom_mask, .rom_size, .sram_bank, .sram_quirk, .noram_quirk, .bus_sram_addr,
		.bus_sram_wdata, .bus_sram_we, .bus_sram_q, .save_change, .rom(rom.bus_client));

endmodule

`default_nettype wire

// File: design/bus_read_path.sv
// One bus transaction at a time; response held until rd_ready.
// ROM reads answer in 3 cycles, SRAM in 2, register space in 1 with 0xFFFF.
`timescale 1ns/100ps
`default_nettype none

module bus_read_path (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [cart_pkg::BUS_ADDR_BITS-1:0]  bus_addr,
	input  logic [cart_pkg::DATA_BITS-1:0]      bus_wdata,
	input  logic                                bus_lwr,
	input  logic                                bus_uwr,
	input  logic                                bus_time,
	input  logic                                bus_valid,
	output logic                                bus_ready,
	output logic [cart_pkg::DATA_BITS-1:0]      rd_data,
	output logic                                rd_valid,
	input  logic                                rd_ready,
	input  logic [cart_pkg::ROM_ADDR_BITS-1:0]  rom_addr,
	input  logic [cart_pkg::ROM_ADDR_BITS-1:0]  rom_mask,
	input  logic [cart_pkg::ROM_SIZE_BITS-1:0]  rom_size,
	input  logic                                sram_bank,
	input  logic                                sram_quirk,
	input  logic                                noram_quirk,
	output logic [cart_pkg::SRAM_ADDR_BITS-1:0] bus_sram_addr,
	output logic [cart_pkg::SRAM_DATA_BITS-1:0] bus_sram_wdata,
	output logic                                bus_sram_we,
	input  logic [cart_pkg::SRAM_DATA_BITS-1:0] bus_sram_q,
	output logic                                save_change,
	rom_port_if.bus_client                      rom
);
	import cart_pkg::*;

	read_src_t req_src;
	read_src_t pend_src;
	logic      accept;
	logic      is_read;
	logic      beyond_image;
	logic      sram_window;
	logic      sram_at_quirk;
	logic      sram_cs;
	logic      load_none;
	logic      load_sram;
	logic      load_rom;

	// ====================
	// SRAM select, address bits 23:21 live in bus_addr[22:20]
	assign beyond_image  = ROM_SIZE_BITS'(bus_addr) >= rom_size;
	assign sram_window   = (bus_addr[22:20] == SRAM_REGION) && !noram_quirk &&
		(sram_bank || (beyond_image && !(&bus_addr[19:18])));
	assign sram_at_quirk = sram_quirk && (bus_addr == SRAM_QUIRK_ADDR);
	assign sram_cs       = (sram_window || sram_at_quirk) && !bus_time;

	// Register space has nothing readable
	always_comb begin
		if (bus_time)
			req_src = SRC_NONE;
		else if (sram_cs)
			req_src = SRC_SRAM;
		else
			req_src = SRC_ROM;
	end

	assign bus_ready = (pend_src == SRC_NONE) && !rd_valid && rom.rd_ready;
	assign accept    = bus_valid && bus_ready;
	assign is_read   = !bus_lwr && !bus_uwr;

	// Storage read issues in the accept cycle
	assign rom.rd_valid = accept && is_read && (req_src == SRC_ROM);
	assign rom.rd_addr  = rom_addr[ROM_WORD_BITS-1:0] & rom_mask[ROM_WORD_BITS-1:0];

	assign bus_sram_addr  = bus_addr[SRAM_ADDR_BITS-1:0];
	assign bus_sram_wdata = bus_wdata[SRAM_DATA_BITS-1:0];
	assign bus_sram_we    = accept && bus_lwr && sram_cs;
	assign save_change    = bus_sram_we;

	assign load_none = accept && is_read && (req_src == SRC_NONE);
	assign load_sram = pend_src == SRC_SRAM;
	assign load_rom  = (pend_src == SRC_ROM) && rom.rsp_valid;

	// ====================
	// Response sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			pend_src <= SRC_NONE;
			rd_valid <= 1'b0;
		end else begin
			if (load_none || load_sram || load_rom)
				rd_valid <= 1'b1;
			else if (rd_ready)
				rd_valid <= 1'b0;
			if (accept && is_read && req_src != SRC_NONE)
				pend_src <= req_src;
			else if (load_sram || load_rom)
				pend_src <= SRC_NONE;
		end
	end

	// SRAM byte shows on both lanes
	always_ff @(posedge clk) begin
		if (load_none)
			rd_data <= '1;
		else if (load_sram)
			rd_data <= {bus_sram_q, bus_sram_q};
		else if (load_rom)
			rd_data <= rom.rsp_data;
	end

endmodule

`default_nettype wire

// File: design/save_ram.sv
// Battery SRAM, one byte per address, registered reads on both ports.
// Both ports writing one address in the same cycle leaves the byte undefined.
`timescale 1ns/100ps
`default_nettype none

module save_ram (
	input  logic                                clk,
	input  logic [cart_pkg::SRAM_ADDR_BITS-1:0] bus_sram_addr,
	input  logic [cart_pkg::SRAM_DATA_BITS-1:0] bus_sram_wdata,
	input  logic                                bus_sram_we,
	output logic [cart_pkg::SRAM_DATA_BITS-1:0] bus_sram_q,
	input  logic [cart_pkg::SRAM_ADDR_BITS-1:0] save_addr,
	input  logic [cart_pkg::SRAM_DATA_BITS-1:0] save_wdata,
	input  logic                                save_we,
	output logic [cart_pkg::SRAM_DATA_BITS-1:0] save_rdata
);
	import cart_pkg::*;

	logic [SRAM_DATA_BITS-1:0] mem [2 ** SRAM_ADDR_BITS];

	// ====================
	// Port A, cart bus
	always_ff @(posedge clk) begin
		if (bus_sram_we)
			mem[bus_sram_addr] <= bus_sram_wdata;
		// Save side lands last on a collision
		if (save_we)
			mem[save_addr] <= save_wdata;
	end

	always_ff @(posedge clk) begin
		bus_sram_q <= mem[bus_sram_addr];
	end

	// ====================
	// Port B, host save access
	always_ff @(posedge clk) begin
		save_rdata <= mem[save_addr];
	end

endmodule

`default_nettype wire

// File: design/rom_store.sv
// On-chip image storage; addresses above ROM_WORDS alias onto it.
// Response comes 2 cycles after a read is accepted; reads may overlap.
`timescale 1ns/100ps
`default_nettype none

module rom_store (
	input  logic      clk,
	input  logic      reset,
	rom_port_if.store rom
);
	import cart_pkg::*;

	logic [DATA_BITS-1:0] mem [ROM_WORDS];
	logic [DATA_BITS-1:0] rd_q;
	logic                 rd_fire;
	logic                 rd_v1;

	// Load writes always go through and block reads for that cycle
	assign rom.wr_ready = 1'b1;
	assign rom.rd_ready = !rom.wr_valid;
	assign rd_fire      = rom.rd_valid && rom.rd_ready;

	// ====================
	// Array and data pipe
	always_ff @(posedge clk) begin
		if (rom.wr_valid)
			mem[rom.wr_addr] <= rom.wr_data;
		if (rd_fire)
			rd_q <= mem[rom.rd_addr];
		rom.rsp_data <= rd_q;
	end

	// Valid travels alongside the data stages
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_v1         <= 1'b0;
			rom.rsp_valid <= 1'b0;
		end else begin
			rd_v1         <= rd_fire;
			rom.rsp_valid <= rd_v1;
		end
	end

endmodule

`default_nettype wire

// File: design/bank_mapper.sv
// Eight-window mapper, live only for images larger than 4 MB.
// Registers take low-lane writes in the timed register space.
`timescale 1ns/100ps
`default_nettype none

module bank_mapper (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [cart_pkg::BUS_ADDR_BITS-1:0] bus_addr,
	input  logic [cart_pkg::DATA_BITS-1:0]     bus_wdata,
	input  logic                               bus_lwr,
	input  logic                               bus_time,
	input  logic                               bus_valid,
	input  logic                               bus_ready,
	input  logic [cart_pkg::ROM_SIZE_BITS-1:0] rom_size,
	output logic [cart_pkg::ROM_ADDR_BITS-1:0] rom_addr,
	output logic                               sram_bank
);
	import cart_pkg::*;

	logic [BANK_BITS-1:0] bank [BANK_COUNT];
	logic                 bank_use;
	logic                 mapper_en;
	logic                 reg_wr;

	assign mapper_en = rom_size > MAPPER_SIZE_WORDS;
	assign reg_wr    = bus_valid && bus_ready && bus_lwr && bus_time;

	always_ff @(posedge clk) begin
		if (reset) begin
			// Identity mapping
			for (int i = 0; i < BANK_COUNT; i++)
				bank[i] <= BANK_BITS'(i);
			bank_use  <= 1'b0;
			sram_bank <= 1'b0;
		end else if (reg_wr) begin
			if (!mapper_en)
				sram_bank <= bus_wdata[0];
			else if (bus_addr[2:0] != 3'd0) begin
				bank[bus_addr[2:0]] <= bus_wdata[BANK_BITS-1:0];
				bank_use            <= 1'b1;
			end else
				sram_bank <= bus_wdata[0];
		end
	end

	// Window from address bits 21:19, offset from bits 18:1
	assign rom_addr = bank_use ?
		{bank[bus_addr[20:18]], bus_addr[WINDOW_BITS-1:0]} :
		ROM_ADDR_BITS'(bus_addr);

endmodule

`default_nettype wire

// File: design/header_detect.sv
// Quirk flags come from the 8-character product code at 0x182.
// Flags clear at each download start and settle after the word at 0x190.
`timescale 1ns/100ps
`default_nettype none

module header_detect (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              dl_active,
	input  logic [cart_pkg::DL_ADDR_BITS-1:0] dl_addr,
	input  logic [cart_pkg::DATA_BITS-1:0]    dl_data,
	input  logic                              dl_valid,
	input  logic                              dl_ready,
	output logic                              sram_quirk,
	output logic                              noram_quirk
);
	import cart_pkg::*;

	localparam logic [DL_ADDR_BITS-1:0] ID_WORD1 = HEADER_ID_ADDR + 25'd2;
	localparam logic [DL_ADDR_BITS-1:0] ID_WORD2 = HEADER_ID_ADDR + 25'd4;
	localparam logic [DL_ADDR_BITS-1:0] ID_WORD3 = HEADER_ID_ADDR + 25'd6;

	// Games that expect SRAM at the fixed address
	localparam int SRAM_ID_COUNT = 5;
	localparam logic [63:0] SRAM_IDS [SRAM_ID_COUNT] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 "
	};
	// Game that probes for RAM and must not find any
	localparam logic [63:0] NORAM_ID = "T-113016";

	logic        dl_active_d;
	logic        accept;
	logic [63:0] cart_id;
	logic        sram_hit;
	logic [15:0] swapped;

	assign accept  = dl_active && dl_valid && dl_ready;
	assign swapped = {dl_data[7:0], dl_data[15:8]};

	always_ff @(posedge clk) begin
		if (accept) begin
			case (dl_addr)
				HEADER_ID_ADDR: cart_id[63:48] <= swapped;
				ID_WORD1:       cart_id[47:32] <= swapped;
				ID_WORD2:       cart_id[31:16] <= swapped;
				ID_WORD3:       cart_id[15:0]  <= swapped;
				default:        ;
			endcase
		end
	end

	always_comb begin
		sram_hit = 1'b0;
		for (int i = 0; i < SRAM_ID_COUNT; i++) begin
			if (cart_id == SRAM_IDS[i])
				sram_hit = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dl_active_d <= 1'b0;
			sram_quirk  <= 1'b0;
			noram_quirk <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_active && !dl_active_d) begin
				sram_quirk  <= 1'b0;
				noram_quirk <= 1'b0;
			end else if (accept && dl_addr == HEADER_END_ADDR) begin
				sram_quirk  <= sram_hit;
				noram_quirk <= (cart_id == NORAM_ID);
			end
		end
	end

endmodule

`default_nettype wire

// File: design/image_loader.sv
// Writes downloaded words at the running size count; storage aliases high counts.
// Mask is the OR of every word address seen since the download started.
`timescale 1ns/100ps
`default_nettype none

module image_loader (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               dl_active,
	input  logic [cart_pkg::DL_ADDR_BITS-1:0]  dl_addr,
	input  logic [cart_pkg::DATA_BITS-1:0]     dl_data,
	input  logic                               dl_valid,
	output logic                               dl_ready,
	output logic [cart_pkg::ROM_SIZE_BITS-1:0] rom_size,
	output logic [cart_pkg::ROM_ADDR_BITS-1:0] rom_mask,
	rom_port_if.load_client                    rom
);
	import cart_pkg::*;

	logic                     dl_active_d;
	logic                     dl_start;
	logic                     accept;
	logic [ROM_SIZE_BITS-1:0] size_base;
	logic [ROM_ADDR_BITS-1:0] mask_base;

	assign dl_ready = rom.wr_ready;
	assign dl_start = dl_active && !dl_active_d;
	assign accept   = dl_active && dl_valid && dl_ready;

	// Start of a download restarts counting in the same cycle
	assign size_base = dl_start ? '0 : rom_size;
	assign mask_base = dl_start ? '0 : rom_mask;

	// ====================
	// Size, mask and write strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			dl_active_d  <= 1'b0;
			rom_size     <= '0;
			rom_mask     <= '0;
			rom.wr_valid <= 1'b0;
		end else begin
			dl_active_d  <= dl_active;
			rom.wr_valid <= accept;
			if (accept) begin
				rom_size <= size_base + 1'b1;
				rom_mask <= mask_base | dl_addr[ROM_ADDR_BITS:1];
			end else begin
				rom_size <= size_base;
				rom_mask <= mask_base;
			end
		end
	end

	// Write payload, bytes swapped into bus order
	always_ff @(posedge clk) begin
		if (accept) begin
			rom.wr_addr <= size_base[ROM_WORD_BITS-1:0];
			rom.wr_data <= {dl_data[7:0], dl_data[15:8]};
		end
	end

endmodule

`default_nettype wire

// File: design/rom_port_if.sv
// Storage port: load writes from the loader, reads from the bus path.
// Writes win; rd_ready drops in any cycle with wr_valid high.
`timescale 1ns/100ps
`default_nettype none

interface rom_port_if;
	import cart_pkg::*;

	logic [ROM_WORD_BITS-1:0] wr_addr;
	logic [DATA_BITS-1:0]     wr_data;
	logic                     wr_valid;
	logic                     wr_ready;

	logic [ROM_WORD_BITS-1:0] rd_addr;
	logic                     rd_valid;
	logic                     rd_ready;
	logic [DATA_BITS-1:0]     rsp_data;
	logic                     rsp_valid;

	modport load_client (output wr_addr, wr_data, wr_valid, input wr_ready);
	modport bus_client (output rd_addr, rd_valid, input rd_ready, rsp_data, rsp_valid);
	modport store (input wr_addr, wr_data, wr_valid, rd_addr, rd_valid,
		output wr_ready, rd_ready, rsp_data, rsp_valid);

endinterface

`default_nettype wire

// File: design/cart_pkg.sv
// Shared widths, address constants and the response source type.
// Bus addresses are word addresses, bit 0 standing for address bit 1.
`default_nettype none

package cart_pkg;

	// ====================
	// Widths
	localparam int DATA_BITS      = 16;
	localparam int SRAM_DATA_BITS = 8;
	localparam int BUS_ADDR_BITS  = 23;
	localparam int DL_ADDR_BITS   = 25;
	localparam int ROM_SIZE_BITS  = 25;
	localparam int ROM_WORD_BITS  = 14;
	localparam int ROM_WORDS      = 2 ** ROM_WORD_BITS;
	localparam int SRAM_ADDR_BITS = 15;

	// Mapper geometry, eight windows of 512 KB each
	localparam int BANK_BITS     = 6;
	localparam int BANK_COUNT    = 8;
	localparam int WINDOW_BITS   = 18;
	localparam int ROM_ADDR_BITS = BANK_BITS + WINDOW_BITS;

	// 2M words, i.e. 4 MB
	localparam logic [ROM_SIZE_BITS-1:0] MAPPER_SIZE_WORDS = 25'h0200000;

	// ====================
	// Address map
	localparam logic [2:0]               SRAM_REGION     = 3'd1;
	localparam logic [BUS_ADDR_BITS-1:0] SRAM_QUIRK_ADDR = 23'h100000;
	localparam logic [DL_ADDR_BITS-1:0]  HEADER_ID_ADDR  = 25'h0000182;
	localparam logic [DL_ADDR_BITS-1:0]  HEADER_END_ADDR = 25'h0000190;

	// Source of an outstanding bus read
	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_ROM,
		SRC_SRAM
	} read_src_t;

endpackage

`default_nettype wire
